// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := wexDecoderTb
FILELIST := wexDecoder.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) include/decodeModel.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | awk '{ print } /^TEST PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD)

// File: design/decodePkg.sv
////////////////////////////////////////////////////////////
// decoded slot info and lane result structs
// bundle form and predicate enums
// idle lane value
////////////////////////////////////////////////////////////

package decodePkg;

	localparam int laneCount = 3;

	typedef enum logic [1:0] {
		predAlways,
		predTrue,
		predFalse
	} predMode;

	typedef enum logic [1:0] {
		formScalar,
		formWex2,
		formWex3,
		formJumbo
	} bundleForm;

	typedef struct packed {
		logic isOp;	// class E or F
		logic isJumbo;
		logic wex;	// flag set and wex mode enabled
		isaPkg::opcode op;
		predMode pred;
		isaPkg::regIdx rn;
		isaPkg::regIdx rm;
		isaPkg::regIdx ro;
		logic [isaPkg::imm8W-1:0] imm8;
		logic hasImm;
		logic [isaPkg::jumboW-1:0] payload;
	} slotInfo;

	typedef struct packed {
		isaPkg::opcode op;
		predMode pred;
		isaPkg::regIdx rn;
		isaPkg::regIdx rm;
		isaPkg::regIdx ro;
		logic [isaPkg::immW-1:0] imm;
	} laneResult;

	// nop on the zero register
	localparam laneResult laneIdle = '{
		op: isaPkg::opNop,
		pred: predAlways,
		rn: isaPkg::regZzr,
		rm: isaPkg::regZzr,
		ro: isaPkg::regZzr,
		imm: '0
	};

endpackage

// File: design/isaPkg.sv
////////////////////////////////////////////////////////////
// instruction encoding for the three-slot bundle decoder
// field widths and bit positions of one 32-bit slot
// class and opcode enums, register index type
////////////////////////////////////////////////////////////

package isaPkg;

	// widths
	localparam int slotW = 32;
	localparam int fetchW = 96;	// three slots per fetch
	localparam int regW = 6;
	localparam int immW = 33;	// lane immediate, sign in bit 32
	localparam int jumboW = 24;	// payload of a D prefix
	localparam int imm8W = 8;

	// slot field positions
	localparam int classLsb = 28;	// class nibble in 31..28
	localparam int wexBit = 27;
	localparam int predBit = 26;	// set means if-false
	localparam int opLsb = 20;
	localparam int rnLsb = 14;
	localparam int rmLsb = 8;
	localparam int roLsb = 0;

	typedef logic [regW-1:0] regIdx;

	localparam regIdx regZzr = 6'd0;	// zero register, also idle filler

	typedef enum logic [3:0] {
		classOther = 4'h0,
		classJumbo = 4'hD,
		classPred = 4'hE,
		classUncond = 4'hF
	} slotClass;

	typedef enum logic [5:0] {
		opNop = 6'd0,
		opAdd = 6'd1,
		opSub = 6'd2,
		opAnd = 6'd3,
		opOr = 6'd4,
		opAddi = 6'd5,
		opLdi = 6'd6,
		opAddx = 6'd7,	// 128-bit, uses lanes A and B
		opMovx = 6'd8,	// 128-bit, uses lanes A and B
		opInvop = 6'd63
	} opcode;

	// first raw opcode that has no meaning
	localparam int opLimit = 9;

endpackage

// File: design/laneRouter.sv
////////////////////////////////////////////////////////////
// lane router for decoded slots
// bundle form, jumbo immediate merge, 128-bit op split
// second pipeline stage driving lanes A, B and C
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module laneRouter (
	input logic clock,
	input logic rstN,
	input logic inValid,
	input decodePkg::slotInfo slot0,
	input decodePkg::slotInfo slot1,
	input decodePkg::slotInfo slot2,
	output logic laneValid,
	output decodePkg::laneResult laneA,
	output decodePkg::laneResult laneB,
	output decodePkg::laneResult laneC,
	output logic [1:0] bundleLen
);

	decodePkg::bundleForm form;
	decodePkg::laneResult lane0;
	decodePkg::laneResult lane1;
	decodePkg::laneResult lane2;
	decodePkg::laneResult nextLane [decodePkg::laneCount];
	logic [1:0] nextLen;

	// apply the immediate and register rules to one slot
	function automatic decodePkg::laneResult buildLane(input decodePkg::slotInfo s);
		decodePkg::laneResult r;
		r.op = s.isOp ? s.op : isaPkg::opInvop;
		r.pred = s.pred;
		r.rn = s.rn;
		r.rm = (s.op == isaPkg::opLdi) ? isaPkg::regZzr : s.rm;
		r.ro = s.hasImm ? isaPkg::regZzr : s.ro;
		r.imm = s.hasImm ?
			{{(isaPkg::immW-isaPkg::imm8W){s.imm8[isaPkg::imm8W-1]}}, s.imm8} : '0;
		return r;
	endfunction

	function automatic logic isWide(input decodePkg::laneResult r);
		return (r.op == isaPkg::opAddx) || (r.op == isaPkg::opMovx);
	endfunction

	// no room for a lane pair inside a wide bundle
	function automatic decodePkg::laneResult wexLane(input decodePkg::laneResult r);
		decodePkg::laneResult w;
		w = r;
		if (isWide(r))
		begin
			w.op = isaPkg::opInvop;
		end
		return w;
	endfunction

	assign lane0 = buildLane(slot0);
	assign lane1 = buildLane(slot1);
	assign lane2 = buildLane(slot2);

	// bundle form, jumbo prefix takes priority
	always_comb
	begin
		if (slot0.isJumbo && slot1.isOp)
		begin
			form = decodePkg::formJumbo;
		end
		else if (!slot0.isOp)
		begin
			form = decodePkg::formScalar;	// lane A ends up invalid
		end
		else if (slot0.wex && slot1.wex)
		begin
			form = decodePkg::formWex3;
		end
		else if (slot0.wex)
		begin
			form = decodePkg::formWex2;
		end
		else
		begin
			form = decodePkg::formScalar;
		end
	end

	always_comb
	begin
		for (int i = 0; i < decodePkg::laneCount; i++)
		begin
			nextLane[i] = decodePkg::laneIdle;
		end
		nextLen = 2'd1;

		case (form)
			decodePkg::formWex3:
			begin
				// reverse slot order across the lanes
				nextLane[0] = wexLane(lane2);
				nextLane[1] = wexLane(lane1);
				nextLane[2] = wexLane(lane0);
				nextLen = 2'd3;
			end
			decodePkg::formWex2:
			begin
				nextLane[0] = wexLane(lane1);
				nextLane[1] = wexLane(lane0);
				nextLen = 2'd2;
			end
			decodePkg::formJumbo:
			begin
				nextLane[0] = lane1;
				nextLane[0].imm = {{(isaPkg::immW-isaPkg::slotW){slot0.payload[isaPkg::jumboW-1]}},
					slot0.payload, slot1.imm8};	// 24 + 8 bits
				nextLen = 2'd2;
			end
			default:
			begin
				nextLane[0] = lane0;
			end
		endcase

		// 128-bit op on an even/odd register pair
		if ((form == decodePkg::formScalar || form == decodePkg::formJumbo) &&
			isWide(nextLane[0]))
		begin
			nextLane[1] = nextLane[0];
			nextLane[0].rn[0] = 1'b0;
			nextLane[0].rm[0] = 1'b0;
			nextLane[0].ro[0] = 1'b0;
			nextLane[1].rn[0] = 1'b1;
			nextLane[1].rm[0] = 1'b1;
			nextLane[1].ro[0] = 1'b1;
		end
	end

	// second pipeline stage, lanes are idle out of reset
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			laneValid <= 1'b0;
			laneA <= decodePkg::laneIdle;
			laneB <= decodePkg::laneIdle;
			laneC <= decodePkg::laneIdle;
			bundleLen <= 2'd0;
		end
		else
		begin
			laneValid <= inValid;
			laneA <= nextLane[0];
			laneB <= nextLane[1];
			laneC <= nextLane[2];
			bundleLen <= nextLen;
		end
	end

	// only a three-wide bundle reaches lane C
	laneCIdle: assert property (@(posedge clock) disable iff (!rstN)
		(bundleLen != 2'd3) |-> (laneC == decodePkg::laneIdle));

	lenNonZero: assert property (@(posedge clock) disable iff (!rstN)
		laneValid |-> (bundleLen != 2'd0));

endmodule

// File: design/slotDecoder.sv
////////////////////////////////////////////////////////////
// single slot decoder
// class, opcode range check, predicate and wex flag
// one register stage of slot info
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module slotDecoder (
	input logic clock,
	input logic rstN,
	input logic inValid,
	input logic [isaPkg::slotW-1:0] slotWord,
	input logic wexEnable,
	output logic outValid,
	output decodePkg::slotInfo slot
);

	isaPkg::slotClass slotCls;
	logic [$bits(isaPkg::opcode)-1:0] rawOp;
	decodePkg::slotInfo nextSlot;

	assign rawOp = slotWord[isaPkg::opLsb +: $bits(isaPkg::opcode)];

	// class nibble
	always_comb
	begin
		case (slotWord[isaPkg::classLsb +: 4])
			4'hF: slotCls = isaPkg::classUncond;
			4'hE: slotCls = isaPkg::classPred;
			4'hD: slotCls = isaPkg::classJumbo;
			default: slotCls = isaPkg::classOther;	// compact forms not handled
		endcase
	end

	always_comb
	begin
		nextSlot = '0;
		nextSlot.isOp = (slotCls == isaPkg::classUncond) || (slotCls == isaPkg::classPred);
		nextSlot.isJumbo = (slotCls == isaPkg::classJumbo);
		nextSlot.wex = slotWord[isaPkg::wexBit] && wexEnable;

		// anything past the last defined opcode is invalid
		if (rawOp < isaPkg::opLimit)
		begin
			nextSlot.op = isaPkg::opcode'(rawOp);
		end
		else
		begin
			nextSlot.op = isaPkg::opInvop;
		end

		if (slotCls == isaPkg::classPred)
		begin
			nextSlot.pred = slotWord[isaPkg::predBit] ? decodePkg::predFalse :
				decodePkg::predTrue;
		end
		else
		begin
			nextSlot.pred = decodePkg::predAlways;	// F and everything else
		end

		nextSlot.rn = slotWord[isaPkg::rnLsb +: isaPkg::regW];
		nextSlot.rm = slotWord[isaPkg::rmLsb +: isaPkg::regW];
		nextSlot.ro = slotWord[isaPkg::roLsb +: isaPkg::regW];
		nextSlot.imm8 = slotWord[isaPkg::imm8W-1:0];	// shares bits with ro
		nextSlot.hasImm = (nextSlot.op == isaPkg::opAddi) ||
			(nextSlot.op == isaPkg::opLdi);
		nextSlot.payload = slotWord[isaPkg::jumboW-1:0];
	end

	// first pipeline stage
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			outValid <= 1'b0;
			slot <= '0;
		end
		else
		begin
			outValid <= inValid;
			slot <= nextSlot;
		end
	end

	// valid must stay driven once out of reset, the router relies on it
	validKnown: assert property (@(posedge clock) disable iff (!rstN)
		!$isunknown(outValid));

endmodule

// File: design/wexDecoder.sv
////////////////////////////////////////////////////////////
// wide-issue bundle decoder top
// three slot decoders feeding the lane router
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module wexDecoder (
	input logic clock,
	input logic rstN,
	input logic fetchValid,
	input logic [isaPkg::fetchW-1:0] fetchWord,
	input logic wexEnable,
	output logic laneValid,
	output decodePkg::laneResult laneA,
	output decodePkg::laneResult laneB,
	output decodePkg::laneResult laneC,
	output logic [1:0] bundleLen
);

	decodePkg::slotInfo slot0;
	decodePkg::slotInfo slot1;
	decodePkg::slotInfo slot2;
	logic slotValid;	// shared by all three slots

	slotDecoder slotDec0 (
		.clock(clock),
		.rstN(rstN),
		.inValid(fetchValid),
		.slotWord(fetchWord[0 +: isaPkg::slotW]),
		.wexEnable(wexEnable),
		.outValid(slotValid),
		.slot(slot0)
	);

	slotDecoder slotDec1 (
		.clock(clock),
		.rstN(rstN),
		.inValid(fetchValid),
		.slotWord(fetchWord[isaPkg::slotW +: isaPkg::slotW]),
		.wexEnable(wexEnable),
		.outValid(),
		.slot(slot1)
	);

	slotDecoder slotDec2 (
		.clock(clock),
		.rstN(rstN),
		.inValid(fetchValid),
		.slotWord(fetchWord[2*isaPkg::slotW +: isaPkg::slotW]),
		.wexEnable(wexEnable),
		.outValid(),
		.slot(slot2)
	);

	laneRouter router (
		.clock(clock),
		.rstN(rstN),
		.inValid(slotValid),
		.slot0(slot0),
		.slot1(slot1),
		.slot2(slot2),
		.laneValid(laneValid),
		.laneA(laneA),
		.laneB(laneB),
		.laneC(laneC),
		.bundleLen(bundleLen)
	);

endmodule

// File: include/decodeModel.svh
////////////////////////////////////////////////////////////
// reference model of the bundle decode rules
// predictLanes and predictLen with their helpers
////////////////////////////////////////////////////////////

`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// one raw slot with the field rules applied
function automatic decodePkg::laneResult modelLane(input logic [31:0] w);
	decodePkg::laneResult r;
	logic [5:0] rawOp;
	logic isOp;
	rawOp = w[25:20];
	isOp = (w[31:28] == 4'hE) || (w[31:28] == 4'hF);
	r.op = (!isOp || rawOp >= 6'd9) ? isaPkg::opInvop : isaPkg::opcode'(rawOp);
	r.pred = decodePkg::predAlways;
	if (w[31:28] == 4'hE)
		r.pred = w[26] ? decodePkg::predFalse : decodePkg::predTrue;
	r.rn = w[19:14];
	r.rm = (rawOp == 6'd6) ? isaPkg::regZzr : w[13:8];
	r.ro = w[5:0];
	r.imm = '0;
	if (rawOp == 6'd5 || rawOp == 6'd6)
	begin
		r.ro = isaPkg::regZzr;
		r.imm = {{25{w[7]}}, w[7:0]};
	end
	return r;
endfunction

function automatic decodePkg::bundleForm modelForm(input logic [95:0] word, input logic wexEn);
	logic op0;
	logic op1;
	op0 = (word[31:28] == 4'hE) || (word[31:28] == 4'hF);
	op1 = (word[63:60] == 4'hE) || (word[63:60] == 4'hF);
	if (word[31:28] == 4'hD && op1)
		return decodePkg::formJumbo;
	if (op0 && word[27] && word[59] && wexEn)
		return decodePkg::formWex3;
	if (op0 && word[27] && wexEn)
		return decodePkg::formWex2;
	return decodePkg::formScalar;
endfunction

function automatic logic isWideModel(input decodePkg::laneResult r);
	return (r.op == isaPkg::opAddx) || (r.op == isaPkg::opMovx);
endfunction

function automatic void predictLanes(input logic [95:0] word, input logic wexEn,
	output decodePkg::laneResult laneA, output decodePkg::laneResult laneB,
	output decodePkg::laneResult laneC);
	decodePkg::bundleForm form;
	decodePkg::laneResult s [3];
	form = modelForm(word, wexEn);
	for (int i = 0; i < 3; i++)
	begin
		s[i] = modelLane(word[32*i +: 32]);
		if (form == decodePkg::formWex2 || form == decodePkg::formWex3)
			if (isWideModel(s[i]))
				s[i].op = isaPkg::opInvop;
	end
	laneA = s[0];
	laneB = decodePkg::laneIdle;
	laneC = decodePkg::laneIdle;
	case (form)
		decodePkg::formWex3:
		begin
			laneA = s[2];
			laneB = s[1];
			laneC = s[0];
		end
		decodePkg::formWex2:
		begin
			laneA = s[1];
			laneB = s[0];
		end
		decodePkg::formJumbo:
		begin
			laneA = s[1];
			laneA.imm = {word[23], word[23:0], word[39:32]};
		end
		default:
		begin
			laneA = s[0];
		end
	endcase
	if ((form == decodePkg::formScalar || form == decodePkg::formJumbo) && isWideModel(laneA))
	begin
		laneB = laneA;
		laneA.rn[0] = 1'b0;
		laneA.rm[0] = 1'b0;
		laneA.ro[0] = 1'b0;
		laneB.rn[0] = 1'b1;
		laneB.rm[0] = 1'b1;
		laneB.ro[0] = 1'b1;
	end
endfunction

function automatic logic [1:0] predictLen(input logic [95:0] word, input logic wexEn);
	case (modelForm(word, wexEn))
		decodePkg::formWex3: return 2'd3;
		decodePkg::formWex2: return 2'd2;
		decodePkg::formJumbo: return 2'd2;
		default: return 2'd1;
	endcase
endfunction

`endif

// File: verification/wexDecoderTb.sv
////////////////////////////////////////////////////////////
// testbench for the bundle decoder
// clock, reset, LFSR stimulus and compare tasks
// directed tests for scalar, wex, jumbo, predicate and stream
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module wexDecoderTb;

	`include "decodeModel.svh"

	localparam int waitLimit = 20;	// cycles
	localparam int streamCount = 200;
	localparam logic [31:0] lfsrSeed = 32'd90633;
	localparam logic [31:0] lfsrTaps = 32'h80200003;

	logic clock;
	logic rstN;
	logic fetchValid;
	logic [isaPkg::fetchW-1:0] fetchWord;
	logic wexEnable;
	logic laneValid;
	decodePkg::laneResult laneA;
	decodePkg::laneResult laneB;
	decodePkg::laneResult laneC;
	logic [1:0] bundleLen;
	logic [31:0] lfsrState;

	wexDecoder uut (
		.clock(clock),
		.rstN(rstN),
		.fetchValid(fetchValid),
		.fetchWord(fetchWord),
		.wexEnable(wexEnable),
		.laneValid(laneValid),
		.laneA(laneA),
		.laneB(laneB),
		.laneC(laneC),
		.bundleLen(bundleLen)
	);

	always #2 clock = ~clock;	// 4 ns period

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkLane(input string name, input decodePkg::laneResult expected,
		input decodePkg::laneResult actual);
		if (actual !== expected)
			abortRun($sformatf("FAIL %s: expected %h actual %h", name, expected, actual));
	endtask

	task automatic checkLen(input string name, input logic [1:0] expected,
		input logic [1:0] actual);
		if (actual !== expected)
			abortRun($sformatf("FAIL %s len: expected %0d actual %0d", name, expected, actual));
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abortRun($sformatf("FAIL %s valid: expected %b actual %b", name, expected, actual));
	endtask

	function automatic logic [31:0] encodeSlot(input logic [3:0] cls, input logic wex,
		input logic predF, input logic [5:0] op, input logic [5:0] rn, input logic [5:0] rm,
		input logic [7:0] low);
		return {cls, wex, predF, op, rn, rm, low};
	endfunction

	function automatic logic [31:0] jumboSlot(input logic [23:0] payload);
		return {4'hD, 4'h0, payload};
	endfunction

	function automatic decodePkg::laneResult makeLane(input isaPkg::opcode op,
		input decodePkg::predMode pred, input isaPkg::regIdx rn, input isaPkg::regIdx rm,
		input isaPkg::regIdx ro, input logic [isaPkg::immW-1:0] imm);
		decodePkg::laneResult r;
		r.op = op;
		r.pred = pred;
		r.rn = rn;
		r.rm = rm;
		r.ro = ro;
		r.imm = imm;
		return r;
	endfunction

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ lfsrTaps) : (s >> 1);
	endfunction

	// one LFSR step per bit
	task automatic takeBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
	endtask

	task automatic randomSlot(output logic [31:0] w);
		logic [31:0] bits;
		w = '0;
		takeBits(2, bits);
		case (bits[1:0])
			2'd0: w[31:28] = 4'hF;
			2'd1: w[31:28] = 4'hE;
			2'd2: w[31:28] = 4'hD;
			default:
			begin
				takeBits(4, bits);
				w[31:28] = bits[3:0];	// any class, mostly invalid
			end
		endcase
		takeBits(2, bits);
		w[27:26] = bits[1:0];
		takeBits(4, bits);
		w[25:20] = {2'b00, bits[3:0]};	// reaches past opMovx
		takeBits(20, bits);
		w[19:0] = bits[19:0];
	endtask

	// drive one bundle and wait for it at the lane outputs
	task automatic sendBundle(input string name, input logic [95:0] word, input logic wexEn);
		int cycles;
		@(negedge clock);
		fetchValid = 1'b1;
		fetchWord = word;
		wexEnable = wexEn;
		@(negedge clock);
		fetchValid = 1'b0;
		cycles = 0;
		while (!laneValid && cycles < waitLimit)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!laneValid)
			abortRun($sformatf("%s: laneValid did not rise within %0d cycles", name, waitLimit));
	endtask

	task automatic checkModel(input string name, input logic [95:0] word, input logic wexEn);
		decodePkg::laneResult expA;
		decodePkg::laneResult expB;
		decodePkg::laneResult expC;
		predictLanes(word, wexEn, expA, expB, expC);
		checkLane({name, " laneA"}, expA, laneA);
		checkLane({name, " laneB"}, expB, laneB);
		checkLane({name, " laneC"}, expC, laneC);
		checkLen(name, predictLen(word, wexEn), bundleLen);
	endtask

	task automatic expectLanes(input string name, input decodePkg::laneResult a,
		input decodePkg::laneResult b, input decodePkg::laneResult c, input logic [1:0] len);
		checkLane({name, " laneA"}, a, laneA);
		checkLane({name, " laneB"}, b, laneB);
		checkLane({name, " laneC"}, c, laneC);
		checkLen(name, len, bundleLen);
	endtask

	task automatic runBundle(input string name, input logic [95:0] word, input logic wexEn);
		sendBundle(name, word, wexEn);
		checkModel(name, word, wexEn);
	endtask

	task automatic testReset();
		checkFlag("testReset", 1'b0, laneValid);
		checkLane("testReset laneA", decodePkg::laneIdle, laneA);
		checkLane("testReset laneB", decodePkg::laneIdle, laneB);
		checkLane("testReset laneC", decodePkg::laneIdle, laneC);
	endtask

	task automatic testScalar();
		logic [31:0] fill;
		logic [31:0] regOp;
		logic [31:0] immOp;
		fill = encodeSlot(4'hF, 1'b1, 1'b0, isaPkg::opOr, 6'd60, 6'd61, 8'd62);
		regOp = encodeSlot(4'hF, 1'b0, 1'b0, isaPkg::opAdd, 6'd3, 6'd4, 8'd5);
		immOp = encodeSlot(4'hF, 1'b0, 1'b0, isaPkg::opAddi, 6'd7, 6'd8, 8'hF0);
		runBundle("testScalar reg", {fill, fill, regOp}, 1'b1);
		expectLanes("testScalar reg", makeLane(isaPkg::opAdd, decodePkg::predAlways,
			6'd3, 6'd4, 6'd5, '0), decodePkg::laneIdle, decodePkg::laneIdle, 2'd1);
		runBundle("testScalar imm", {fill, fill, immOp}, 1'b1);
		expectLanes("testScalar imm", makeLane(isaPkg::opAddi, decodePkg::predAlways,
			6'd7, 6'd8, isaPkg::regZzr, {{25{1'b1}}, 8'hF0}),
			decodePkg::laneIdle, decodePkg::laneIdle, 2'd1);
	endtask

	task automatic testWex();
		logic [31:0] s0;
		logic [31:0] s1;
		logic [31:0] s1w;
		logic [31:0] s2;
		decodePkg::laneResult l0;
		decodePkg::laneResult l1;
		decodePkg::laneResult l2;
		s0 = encodeSlot(4'hF, 1'b1, 1'b0, isaPkg::opAdd, 6'd1, 6'd2, 8'd3);
		s1 = encodeSlot(4'hE, 1'b0, 1'b0, isaPkg::opSub, 6'd4, 6'd5, 8'd6);
		s1w = encodeSlot(4'hE, 1'b1, 1'b0, isaPkg::opSub, 6'd4, 6'd5, 8'd6);
		s2 = encodeSlot(4'hF, 1'b0, 1'b0, isaPkg::opOr, 6'd7, 6'd8, 8'd9);
		l0 = makeLane(isaPkg::opAdd, decodePkg::predAlways, 6'd1, 6'd2, 6'd3, '0);
		l1 = makeLane(isaPkg::opSub, decodePkg::predTrue, 6'd4, 6'd5, 6'd6, '0);
		l2 = makeLane(isaPkg::opOr, decodePkg::predAlways, 6'd7, 6'd8, 6'd9, '0);
		runBundle("testWex wex2", {s2, s1, s0}, 1'b1);
		expectLanes("testWex wex2", l1, l0, decodePkg::laneIdle, 2'd2);
		runBundle("testWex wex3", {s2, s1w, s0}, 1'b1);
		expectLanes("testWex wex3", l2, l1, l0, 2'd3);
		// mode off, flags no longer count
		runBundle("testWex off", {s2, s1w, s0}, 1'b0);
		expectLanes("testWex off", l0, decodePkg::laneIdle, decodePkg::laneIdle, 2'd1);
	endtask

	task automatic testJumbo();
		logic [31:0] prefix;
		logic [31:0] addi;
		logic [31:0] junk;
		prefix = jumboSlot(24'h812345);
		addi = encodeSlot(4'hF, 1'b1, 1'b0, isaPkg::opAddi, 6'd9, 6'd10, 8'h67);
		junk = encodeSlot(4'h3, 1'b0, 1'b0, isaPkg::opAdd, 6'd11, 6'd12, 8'd13);
		runBundle("testJumbo addi", {junk, addi, prefix}, 1'b1);
		expectLanes("testJumbo addi", makeLane(isaPkg::opAddi, decodePkg::predAlways,
			6'd9, 6'd10, isaPkg::regZzr, {1'b1, 24'h812345, 8'h67}),
			decodePkg::laneIdle, decodePkg::laneIdle, 2'd2);
		runBundle("testJumbo nonop", {addi, junk, prefix}, 1'b1);	// model gives invop
	endtask

	task automatic testPredWide();
		logic [31:0] fill;
		logic [31:0] w0;
		logic [31:0] w1;
		fill = encodeSlot(4'h0, 1'b0, 1'b0, 6'd0, 6'd0, 6'd0, 8'd0);
		w0 = encodeSlot(4'hE, 1'b0, 1'b0, isaPkg::opAnd, 6'd2, 6'd3, 8'd4);
		runBundle("testPredWide true", {fill, fill, w0}, 1'b0);
		checkLane("testPredWide true laneA", makeLane(isaPkg::opAnd, decodePkg::predTrue,
			6'd2, 6'd3, 6'd4, '0), laneA);
		w0 = encodeSlot(4'hE, 1'b0, 1'b1, isaPkg::opAnd, 6'd2, 6'd3, 8'd4);
		runBundle("testPredWide false", {fill, fill, w0}, 1'b0);
		checkLane("testPredWide false laneA", makeLane(isaPkg::opAnd, decodePkg::predFalse,
			6'd2, 6'd3, 6'd4, '0), laneA);

		// register pair split
		w0 = encodeSlot(4'hF, 1'b0, 1'b0, isaPkg::opAddx, 6'd5, 6'd9, 8'd14);
		runBundle("testPredWide split", {fill, fill, w0}, 1'b1);
		expectLanes("testPredWide split",
			makeLane(isaPkg::opAddx, decodePkg::predAlways, 6'd4, 6'd8, 6'd14, '0),
			makeLane(isaPkg::opAddx, decodePkg::predAlways, 6'd5, 6'd9, 6'd15, '0),
			decodePkg::laneIdle, 2'd1);

		w0 = encodeSlot(4'hF, 1'b1, 1'b0, isaPkg::opAddx, 6'd5, 6'd9, 8'd14);
		w1 = encodeSlot(4'hF, 1'b0, 1'b0, isaPkg::opSub, 6'd20, 6'd21, 8'd22);
		runBundle("testPredWide wex", {fill, w1, w0}, 1'b1);
		expectLanes("testPredWide wex",
			makeLane(isaPkg::opSub, decodePkg::predAlways, 6'd20, 6'd21, 6'd22, '0),
			makeLane(isaPkg::opInvop, decodePkg::predAlways, 6'd5, 6'd9, 6'd14, '0),
			decodePkg::laneIdle, 2'd2);

		w0 = encodeSlot(4'hF, 1'b0, 1'b0, 6'd12, 6'd1, 6'd2, 8'd3);
		runBundle("testPredWide badop", {fill, fill, w0}, 1'b1);
		checkLane("testPredWide badop laneA", makeLane(isaPkg::opInvop, decodePkg::predAlways,
			6'd1, 6'd2, 6'd3, '0), laneA);
	endtask

	// one bundle per cycle, results exactly two cycles later
	task automatic testStream();
		logic [95:0] words [streamCount];
		logic modes [streamCount];
		logic [31:0] w;
		logic [31:0] bits;
		string name;
		for (int i = 0; i < streamCount; i++)
		begin
			for (int s = 0; s < 3; s++)
			begin
				randomSlot(w);
				words[i][32*s +: 32] = w;
			end
			takeBits(1, bits);
			modes[i] = bits[0];
		end
		for (int k = 0; k < streamCount + 2; k++)
		begin
			@(negedge clock);
			if (k >= 2)
			begin
				name = $sformatf("testStream bundle %0d", k - 2);
				checkFlag(name, 1'b1, laneValid);
				checkModel(name, words[k-2], modes[k-2]);
			end
			if (k < streamCount)
			begin
				fetchValid = 1'b1;
				fetchWord = words[k];
				wexEnable = modes[k];
			end
			else
			begin
				fetchValid = 1'b0;
			end
		end
	endtask

	initial
	begin
		clock = 1'b0;
		rstN = 1'b0;
		fetchValid = 1'b0;
		fetchWord = '0;
		wexEnable = 1'b0;
		lfsrState = lfsrSeed;
		repeat (8) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
		testReset();
		testScalar();
		testWex();
		testJumbo();
		testPredWide();
		testStream();
		$display("TEST PASS");
		$finish;
	end

endmodule

// File: wexDecoder.f
+incdir+include
design/isaPkg.sv
design/decodePkg.sv
design/slotDecoder.sv
design/laneRouter.sv
design/wexDecoder.sv
verification/wexDecoderTb.sv
